//--- rtl/led_brightness_ramp.sv
`timescale 1ns/1ps

module led_brightness_ramp (
    input  logic                     pclk,
    input  logic                     nreset,
    input  logic                     period_start,
    input  led_pwm_pkg::period_cfg_t cfg,
    output led_pwm_pkg::level_t      level
);
    import led_pwm_pkg::*;

    logic           dir_up;
    logic [PWM_W:0] step;    // one spare bit for the overflow test
    logic [PWM_W:0] up_sum;

    assign step   = (PWM_W + 1)'(cfg.state.pulse_rate);
    assign up_sum = {1'b0, level} + step;

    // triangle between 0 and 255, one step per period
    always_ff @(posedge pclk) begin
        if (!nreset) begin
            level  <= LEVEL_MAX;
            dir_up <= 1'b1;
        end else if (period_start) begin
            if (!cfg.pulse_on) begin
                level  <= LEVEL_MAX;  // full brightness, no breathing
                dir_up <= 1'b1;
            end else if (dir_up) begin
                if (up_sum >= {1'b0, LEVEL_MAX}) begin
                    level  <= LEVEL_MAX;
                    dir_up <= 1'b0;  // turn at the top
                end else begin
                    level <= up_sum[PWM_W-1:0];
                end
            end else begin
                if (step >= {1'b0, level}) begin
                    level  <= '0;
                    dir_up <= 1'b1;  // turn at the bottom
                end else begin
                    level <= level - step[PWM_W-1:0];
                end
            end
        end
    end

endmodule

//--- rtl/led_bus_regs.sv
`timescale 1ns/1ps

module led_bus_regs (
    input  logic                     pclk,
    input  logic                     nreset,
    input  logic                     bus_write_en,
    input  logic                     bus_read_en,
    input  led_regs_pkg::reg_addr_t  bus_addr,
    input  led_regs_pkg::bus_word_t  bus_write_data,
    output led_regs_pkg::bus_word_t  bus_read_data,
    input  logic                     active_sel,
    input  led_pwm_pkg::level_t      level,
    output led_regs_pkg::led_state_t pending_1,
    output led_regs_pkg::led_state_t pending_2,
    output logic                     pulse_enable
);
    import led_regs_pkg::*;

    led_ctrl_t  ctrl;
    logic [1:0] reg_idx;
    bus_word_t  status_word;
    bus_word_t  read_mux;

    assign reg_idx      = bus_addr[REG_IDX_HI:REG_IDX_LO];
    assign pulse_enable = ctrl.pulse_enable;

    // status: active select above the current level, rest zero
    always_comb begin
        status_word = '0;
        status_word[STATUS_SEL_BIT] = active_sel;
        status_word[STATUS_SEL_BIT-1:0] = level;
    end

    always_comb begin
        case (reg_idx)
            ADDR_CTRL[REG_IDX_HI:REG_IDX_LO]:    read_mux = ctrl;
            ADDR_STATE_1[REG_IDX_HI:REG_IDX_LO]: read_mux = pending_1;
            ADDR_STATE_2[REG_IDX_HI:REG_IDX_LO]: read_mux = pending_2;
            ADDR_STATUS[REG_IDX_HI:REG_IDX_LO]:  read_mux = status_word;
            default:                             read_mux = '0;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (!nreset) begin
            ctrl          <= '0;
            pending_1     <= '0;
            pending_2     <= '0;
            bus_read_data <= '0;
        end else if (bus_write_en) begin  // write wins over read
            case (reg_idx)
                ADDR_CTRL[REG_IDX_HI:REG_IDX_LO]: begin
                    ctrl <= bus_write_data;
                end
                ADDR_STATE_1[REG_IDX_HI:REG_IDX_LO]: begin
                    pending_1 <= bus_write_data;
                end
                ADDR_STATE_2[REG_IDX_HI:REG_IDX_LO]: begin
                    pending_2 <= bus_write_data;
                end
                default: ;  // status ignores writes
            endcase
        end else if (bus_read_en) begin
            bus_read_data <= read_mux;  // held until the next read
        end
    end

endmodule

//--- rtl/led_pwm_channel.sv
`timescale 1ns/1ps

module led_pwm_channel (
    input  logic                    pclk,
    input  logic                    nreset,
    input  logic                    period_start,
    input  led_pwm_pkg::pwm_count_t pwm_count,
    input  led_pwm_pkg::color_t     color,
    input  logic                    en,
    input  logic                    pulse_on,
    input  led_pwm_pkg::level_t     level,
    output logic                    pwm
);
    import led_pwm_pkg::*;

    logic [2*PWM_W-1:0] product;
    duty_t              duty_next;
    duty_t              duty_q;
    duty_t              duty_now;

    assign product = color * level;  // level still pre-update here

    always_comb begin
        if (!en)
            duty_next = '0;
        else if (pulse_on)
            duty_next = product[2*PWM_W-1:PWM_W];  // scale by level/256
        else
            duty_next = color;
    end

    // new duty already applies on count 0
    assign duty_now = period_start ? duty_next : duty_q;

    always_ff @(posedge pclk) begin
        if (!nreset) begin
            duty_q <= '0;
            pwm    <= 1'b0;
        end else begin
            if (period_start)
                duty_q <= duty_next;
            pwm <= (pwm_count < duty_now);  // duty 0 stays low
        end
    end

endmodule

//--- rtl/led_pwm_pkg.sv
package led_pwm_pkg;

    localparam int PWM_W = 8;

    typedef logic [PWM_W-1:0] color_t;
    typedef logic [PWM_W-1:0] level_t;
    typedef logic [PWM_W-1:0] duty_t;
    typedef logic [PWM_W-1:0] pwm_count_t;

    localparam level_t     LEVEL_MAX     = 8'd255;
    localparam pwm_count_t PWM_COUNT_MAX = 8'd255;

    // snapshot taken at each period boundary
    typedef struct packed {
        led_regs_pkg::led_state_t state;
        logic                     pulse_on;  // breathing active this period
    } period_cfg_t;

endpackage

//--- rtl/led_regs_pkg.sv
package led_regs_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] bus_word_t;
    typedef logic [6:0]  pulse_rate_t;

    // colour state word, same layout as the register
    typedef struct packed {
        logic        en;
        pulse_rate_t pulse_rate;
        logic [7:0]  red;
        logic [7:0]  green;
        logic [7:0]  blue;
    } led_state_t;

    typedef struct packed {
        logic [30:0] reserved;      // kept as written
        logic        pulse_enable;  // global breathing switch
    } led_ctrl_t;

    // word index lives in address bits 3..2
    localparam int REG_IDX_HI = 3;
    localparam int REG_IDX_LO = 2;

    localparam reg_addr_t ADDR_CTRL    = 8'h00;
    localparam reg_addr_t ADDR_STATE_1 = 8'h04;
    localparam reg_addr_t ADDR_STATE_2 = 8'h08;
    localparam reg_addr_t ADDR_STATUS  = 8'h0C;  // read-only

    localparam int STATUS_SEL_BIT = 8;  // level sits below it

endpackage

//--- rtl/led_state_sequencer.sv
`timescale 1ns/1ps

module led_state_sequencer #(
    parameter int CLK_DIV = 1
) (
    input  logic                     pclk,
    input  logic                     nreset,
    input  led_regs_pkg::led_state_t pending_1,
    input  led_regs_pkg::led_state_t pending_2,
    input  logic                     pulse_enable,
    output logic                     period_start,
    output led_pwm_pkg::pwm_count_t  pwm_count,
    output led_pwm_pkg::period_cfg_t cfg,
    output logic                     active_sel
);
    import led_regs_pkg::*;
    import led_pwm_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic             wrap;
    led_state_t       state_1;
    led_state_t       state_2;
    led_state_t       active_state;
    logic             pulse_en_q;

    assign tick = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign wrap = tick && (pwm_count == PWM_COUNT_MAX);

    // prescaler, one count per CLK_DIV clocks
    always_ff @(posedge pclk) begin
        if (!nreset) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // starts at 255 so the first wrap comes one count after reset
    always_ff @(posedge pclk) begin
        if (!nreset) begin
            pwm_count    <= PWM_COUNT_MAX;
            period_start <= 1'b0;
        end else begin
            period_start <= wrap;
            if (tick)
                pwm_count <= pwm_count + 1'b1;  // 255 rolls over to 0
        end
    end

    always_ff @(posedge pclk) begin
        if (!nreset) begin
            state_1    <= '0;
            state_2    <= '0;
            pulse_en_q <= 1'b0;
            active_sel <= 1'b0;
        end else if (wrap) begin
            state_1    <= pending_1;
            state_2    <= pending_2;
            pulse_en_q <= pulse_enable;
            active_sel <= ~active_sel;
        end
    end

    // select has already flipped, so 1 means state 1 was picked
    assign active_state = active_sel ? state_1 : state_2;
    assign cfg.state    = active_state;
    assign cfg.pulse_on = pulse_en_q && (active_state.pulse_rate != '0);

endmodule

//--- rtl/rgb_led.sv
`timescale 1ns/1ps

module rgb_led #(
    parameter int CLK_DIV = 1
) (
    input  logic                    pclk,
    input  logic                    nreset,
    input  logic                    bus_write_en,
    input  logic                    bus_read_en,
    input  led_regs_pkg::reg_addr_t bus_addr,
    input  led_regs_pkg::bus_word_t bus_write_data,
    output led_regs_pkg::bus_word_t bus_read_data,
    output logic                    pwm_r,
    output logic                    pwm_g,
    output logic                    pwm_b
);
    import led_regs_pkg::*;
    import led_pwm_pkg::*;

    led_state_t  pending_1;
    led_state_t  pending_2;
    logic        pulse_enable;
    logic        active_sel;
    logic        period_start;
    pwm_count_t  pwm_count;
    period_cfg_t cfg;
    level_t      level;
    color_t      ch_color [3];
    logic [2:0]  ch_pwm;

    led_bus_regs regs_inst (
        .pclk           (pclk),
        .nreset         (nreset),
        .bus_write_en   (bus_write_en),
        .bus_read_en    (bus_read_en),
        .bus_addr       (bus_addr),
        .bus_write_data (bus_write_data),
        .bus_read_data  (bus_read_data),
        .active_sel     (active_sel),
        .level          (level),
        .pending_1      (pending_1),
        .pending_2      (pending_2),
        .pulse_enable   (pulse_enable)
    );

    led_state_sequencer #(
        .CLK_DIV (CLK_DIV)
    ) seq_inst (
        .pclk         (pclk),
        .nreset       (nreset),
        .pending_1    (pending_1),
        .pending_2    (pending_2),
        .pulse_enable (pulse_enable),
        .period_start (period_start),
        .pwm_count    (pwm_count),
        .cfg          (cfg),
        .active_sel   (active_sel)
    );

    led_brightness_ramp ramp_inst (
        .pclk         (pclk),
        .nreset       (nreset),
        .period_start (period_start),
        .cfg          (cfg),
        .level        (level)
    );

    // r, g, b order
    assign ch_color[0] = cfg.state.red;
    assign ch_color[1] = cfg.state.green;
    assign ch_color[2] = cfg.state.blue;

    for (genvar i = 0; i < 3; i++) begin : g_channel
        led_pwm_channel channel_inst (
            .pclk         (pclk),
            .nreset       (nreset),
            .period_start (period_start),
            .pwm_count    (pwm_count),
            .color        (ch_color[i]),
            .en           (cfg.state.en),
            .pulse_on     (cfg.pulse_on),
            .level        (level),
            .pwm          (ch_pwm[i])
        );
    end

    assign pwm_r = ch_pwm[0];
    assign pwm_g = ch_pwm[1];
    assign pwm_b = ch_pwm[2];

endmodule

//--- tb.f
+incdir+tests
rtl/led_regs_pkg.sv
rtl/led_pwm_pkg.sv
rtl/led_bus_regs.sv
rtl/led_state_sequencer.sv
rtl/led_brightness_ramp.sv
rtl/led_pwm_channel.sv
rtl/rgb_led.sv
tests/tb_clock_gen.sv
tests/rgb_led_tb.sv

//--- tests/rgb_led_tb_checks.svh
`ifndef RGB_LED_TB_CHECKS_SVH
`define RGB_LED_TB_CHECKS_SVH

// write is taken on the second edge and the shadow follows it there
task automatic bus_write(input reg_addr_t addr, input bus_word_t data);
    @(posedge pclk);
    bus_write_en   <= 1'b1;
    bus_addr       <= addr;
    bus_write_data <= data;
    @(posedge pclk);
    bus_write_en <= 1'b0;
    case (addr)
        ADDR_CTRL:    sh_ctrl = data;
        ADDR_STATE_1: sh_state_1 = data;
        ADDR_STATE_2: sh_state_2 = data;
        default: ;
    endcase
endtask

task automatic bus_read(input reg_addr_t addr, output bus_word_t data);
    @(posedge pclk);
    bus_read_en <= 1'b1;
    bus_addr    <= addr;
    @(posedge pclk);
    bus_read_en <= 1'b0;
    @(negedge pclk);  // read data settled by now
    data = bus_read_data;
endtask

// expected high counts per period from colour, level and enable
function automatic color_t ref_duty(color_t color, logic en, logic pulse_on, level_t lvl);
    if (!en)
        return '0;
    if (!pulse_on)
        return color;
    return color_t'((int'(color) * int'(lvl)) / 256);
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("FAILED at %0d ns: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1);
    end
endtask

`endif

//--- tests/rgb_led_tb.sv
`timescale 1ns/1ps

module rgb_led_tb;
    import led_regs_pkg::*;
    import led_pwm_pkg::*;

    localparam int NUM_PERIODS   = 22;
    localparam int PERIOD_CYCLES = 256;
    localparam int TIMEOUT_NS    = (NUM_PERIODS + 4) * PERIOD_CYCLES * 8;

    logic       pclk;
    logic       nreset;
    logic       bus_write_en;
    logic       bus_read_en;
    reg_addr_t  bus_addr;
    bus_word_t  bus_write_data;
    bus_word_t  bus_read_data;
    logic       pwm_r;
    logic       pwm_g;
    logic       pwm_b;

    bus_word_t  sh_ctrl = '0;     // what the DUT registers should hold
    led_state_t sh_state_1 = '0;
    led_state_t sh_state_2 = '0;

    logic        model_sel = 1'b0;
    level_t      model_level = LEVEL_MAX;
    logic        model_dir_up = 1'b1;
    color_t      exp_r;
    color_t      exp_g;
    color_t      exp_b;
    int          cur_period = -1;
    logic        monitor_done = 1'b0;
    logic [31:0] rng_state = 32'd62592;

    `include "rgb_led_tb_checks.svh"

    tb_clock_gen clock_inst (
        .pclk   (pclk),
        .nreset (nreset)
    );

    rgb_led #(
        .CLK_DIV (1)
    ) rgb_led_inst (
        .pclk           (pclk),
        .nreset         (nreset),
        .bus_write_en   (bus_write_en),
        .bus_read_en    (bus_read_en),
        .bus_addr       (bus_addr),
        .bus_write_data (bus_write_data),
        .bus_read_data  (bus_read_data),
        .pwm_r          (pwm_r),
        .pwm_g          (pwm_g),
        .pwm_b          (pwm_b)
    );

    // triangle between 0 and 255 clamped at both turns
    task automatic advance_level(input logic pulse_on, input int rate);
        int next;
        next = model_dir_up ? int'(model_level) + rate : int'(model_level) - rate;
        if (!pulse_on) begin
            model_level  = LEVEL_MAX;
            model_dir_up = 1'b1;
        end else if (next >= 255) begin
            model_level  = LEVEL_MAX;
            model_dir_up = 1'b0;
        end else if (next <= 0) begin
            model_level  = '0;
            model_dir_up = 1'b1;
        end else begin
            model_level = level_t'(next);
        end
    endtask

    // latch pending and flip select at the boundary with duty from the old level
    task automatic latch_period();
        led_state_t st;
        logic       pulse_on;
        model_sel = ~model_sel;
        st        = model_sel ? sh_state_1 : sh_state_2;
        pulse_on  = sh_ctrl[0] && (st.pulse_rate != 0);
        exp_r     = ref_duty(st.red, st.en, pulse_on, model_level);
        exp_g     = ref_duty(st.green, st.en, pulse_on, model_level);
        exp_b     = ref_duty(st.blue, st.en, pulse_on, model_level);
        advance_level(pulse_on, int'(st.pulse_rate));
    endtask

    function automatic bus_word_t status_expected();
        return {23'd0, model_sel, model_level};
    endfunction

    // high cycles counted over one 256-cycle window per period
    initial begin : monitor
        int hi_r;
        int hi_g;
        int hi_b;
        @(posedge nreset);
        @(posedge pclk);  // first wrap
        latch_period();
        @(posedge pclk);
        for (int p = 0; p < NUM_PERIODS; p++) begin
            hi_r = 0;
            hi_g = 0;
            hi_b = 0;
            cur_period = p;
            repeat (PERIOD_CYCLES) begin
                @(negedge pclk);
                hi_r += pwm_r;
                hi_g += pwm_g;
                hi_b += pwm_b;
            end
            check_value($sformatf("pwm_r high count, period %0d", p), exp_r, hi_r);
            check_value($sformatf("pwm_g high count, period %0d", p), exp_g, hi_g);
            check_value($sformatf("pwm_b high count, period %0d", p), exp_b, hi_b);
            latch_period();
        end
        monitor_done = 1'b1;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin : stimulus
        bus_word_t  rd;
        led_state_t st;
        bus_write_en   = 1'b0;
        bus_read_en    = 1'b0;
        bus_addr       = '0;
        bus_write_data = '0;
        @(posedge nreset);
        @(negedge pclk);
        // check 1
        check_value("bus_read_data", 32'd0, bus_read_data);
        check_value("pwm_r", 32'd0, pwm_r);
        check_value("pwm_g", 32'd0, pwm_g);
        check_value("pwm_b", 32'd0, pwm_b);
        wait (cur_period == 0);
        repeat (8) @(posedge pclk);
        bus_read(ADDR_CTRL, rd);
        check_value("ctrl", 32'd0, rd);
        bus_read(ADDR_STATE_1, rd);
        check_value("state_1", 32'd0, rd);
        bus_read(ADDR_STATE_2, rd);
        check_value("state_2", 32'd0, rd);
        bus_read(ADDR_STATUS, rd);
        check_value("status", status_expected(), rd);
        // check 2 with reserved bits set and breathing left off
        bus_write(ADDR_CTRL, 32'hA5A5_5A5A);
        bus_read(ADDR_CTRL, rd);
        check_value("ctrl", 32'hA5A5_5A5A, rd);
        st    = next_random();
        st.en = 1'b1;
        bus_write(ADDR_STATE_1, st);
        bus_read(ADDR_STATE_1, rd);
        check_value("state_1", st, rd);
        st       = next_random();
        st.en    = 1'b1;
        st.green = '0;  // zero duty channel
        bus_write(ADDR_STATE_2, st);
        bus_read(ADDR_STATE_2, rd);
        check_value("state_2", st, rd);
        for (int p = 1; p < NUM_PERIODS; p++) begin
            wait (cur_period == p);
            repeat (8) @(posedge pclk);
            if (p == 3) begin
                // check 4 writes mid-period and disables state 2
                st    = next_random();
                st.en = 1'b1;
                bus_write(ADDR_STATE_1, st);
                st     = next_random();
                st.en  = 1'b0;
                st.red = 8'hFF;
                bus_write(ADDR_STATE_2, st);
            end else if (p == 5) begin
                // check 5 turns on breathing at rate 40 from the next period
                st            = next_random();
                st.en         = 1'b1;
                st.pulse_rate = 7'd40;
                bus_write(ADDR_STATE_1, st);
                st            = next_random();
                st.en         = 1'b1;
                st.pulse_rate = 7'd40;
                bus_write(ADDR_STATE_2, st);
                bus_write(ADDR_CTRL, 32'h0000_0001);
            end
            bus_read(ADDR_STATUS, rd);
            check_value($sformatf("status, period %0d", p), status_expected(), rd);
        end
        wait (monitor_done);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic pclk,
    output logic nreset
);

    initial begin
        pclk = 1'b0;
        forever #(PERIOD_NS / 2.0) pclk = ~pclk;
    end

    // released on a rising edge, seen by the DUT one edge later
    initial begin
        nreset = 1'b0;
        repeat (RESET_CYCLES) @(posedge pclk);
        nreset <= 1'b1;
    end

endmodule
